//--- files.f
hw/decode_pkg.sv
hw/ctrl_decoder.sv
hw/bypass_unit.sv
hw/operand_select.sv
hw/decode_stage.sv
bench/decode_checker.sv
bench/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
BUILD_DIR ?= build
LOG       ?= sim.log
SOURCES   := $(shell cat files.f)

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): files.f $(SOURCES)
	$(VERILATOR) --binary --top-module $(TOP) -f files.f -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int WAIT_LIMIT = 50;

    typedef struct packed {
        logic [31:0] inst;
        logic [4:0]  ex_dst;
        logic [4:0]  m1_dst;
        logic [4:0]  m2_dst;
        logic [2:0]  valid;  // ex, mem1, mem2
        logic [31:1] onfly;
        logic        hazard;
        logic [3:0]  alu_op;
        alu_sel_e    s1;
        alu_sel_e    s2;
        wb_sel_e     wb;
        logic [4:0]  wb_reg;
        cmp_op_e     cmp;
        mem_op_e     mem;
        logic [2:0]  fn;
        logic [1:0]  req;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    inst_u       inst;
    logic [31:0] pc;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    fwd_src_t    ex_fwd;
    fwd_src_t    mem1_fwd;
    fwd_src_t    mem2_fwd;
    logic [31:1] onfly;
    logic        out_valid;
    logic        out_ready;
    issue_t      issue;
    logic        exp_push;
    issue_t      exp_issue;
    int          exp_id;
    int          exp_lat;
    logic        stall_expect;
    logic        idle_check;
    int          checked;
    int          errors;
    int          seed;
    row_t        rows[$];

    decode_stage uut (
        .clk_i (clk), .rst_n_i (rst_n),
        .in_valid_i (in_valid), .in_ready_o (in_ready), .inst_i (inst), .pc_i (pc),
        .reg_raddr1_o (raddr1), .reg_raddr2_o (raddr2),
        .reg_rdata1_i (32'h1000_0000 + 32'(raddr1)),  // Register file model
        .reg_rdata2_i (32'h1000_0000 + 32'(raddr2)),
        .ex_fwd_i (ex_fwd), .mem1_fwd_i (mem1_fwd), .mem2_fwd_i (mem2_fwd),
        .onfly_mask_i (onfly),
        .out_valid_o (out_valid), .out_ready_i (out_ready), .issue_o (issue)
    );

    decode_checker chk (
        .clk_i (clk), .rst_n_i (rst_n), .out_valid_i (out_valid), .out_ready_i (out_ready),
        .in_ready_i (in_ready), .issue_i (issue), .exp_push_i (exp_push),
        .exp_issue_i (exp_issue), .exp_id_i (exp_id), .exp_lat_i (exp_lat),
        .stall_expect_i (stall_expect),
        .idle_check_i (idle_check), .checked_o (checked), .errors_o (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input logic [31:0] i, input logic [4:0] e, m1, m2,
                           input logic [2:0] v, input logic [31:1] of, input logic hz,
                           input logic [3:0] op, input alu_sel_e s1, s2, input wb_sel_e wb,
                           input logic [4:0] rd, input cmp_op_e c, input mem_op_e m,
                           input logic [2:0] fn, input logic [1:0] rq);
        rows.push_back('{i, e, m1, m2, v, of, hz, op, s1, s2, wb, rd, c, m, fn, rq});
    endtask

    task automatic apply_fwd(input row_t r, input bit cleared);
        ex_fwd   = '{dst: r.ex_dst, data: $random(seed), data_valid: cleared | r.valid[2]};
        mem1_fwd = '{dst: r.m1_dst, data: $random(seed), data_valid: cleared | r.valid[1]};
        mem2_fwd = '{dst: r.m2_dst, data: $random(seed), data_valid: cleared | r.valid[0]};
        onfly    = cleared ? '0 : r.onfly;
    endtask

    function automatic logic [31:0] src_val(input logic [4:0] rs);
        if (rs == 5'd0) return 32'd0;
        if (ex_fwd.dst == rs) return ex_fwd.data;
        if (mem1_fwd.dst == rs) return mem1_fwd.data;
        if (mem2_fwd.dst == rs) return mem2_fwd.data;
        return 32'h1000_0000 + 32'(rs);
    endfunction

    function automatic logic [31:0] sel_val(input alu_sel_e s, input logic [31:0] w,
                                            input logic [31:0] p, input logic [31:0] rd);
        case (s)
            SEL_REG:   return rd;
            SEL_SHAMT: return {27'd0, w[24:20]};
            SEL_I:     return {{20{w[31]}}, w[31:20]};
            SEL_U:     return {w[31:12], 12'd0};
            SEL_PC:    return p;
            SEL_J:     return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            SEL_S:     return {{20{w[31]}}, w[31:25], w[11:7]};
            SEL_B:     return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            default:   return 32'd0;
        endcase
    endfunction

    function automatic issue_t expected(input row_t r, input logic [31:0] p);
        issue_t e;
        e.ctrl           = '0;
        e.ctrl.alu_op    = r.alu_op;
        e.ctrl.alu_num1_sel = r.s1;
        e.ctrl.alu_num2_sel = r.s2;
        e.ctrl.wb_sel    = r.wb;
        e.ctrl.wb_reg    = r.wb_reg;
        e.ctrl.pc_sel    = (r.cmp == CMP_NONE) ? PC_SEQ : PC_BRANCH;
        e.ctrl.cmp_op    = r.cmp;
        e.ctrl.cmp_funct = (r.cmp == CMP_COMPARE) ? r.fn : 3'd0;
        e.ctrl.mem_op    = r.mem;
        e.ctrl.mem_funct = (r.mem != MEM_NONE) ? r.fn : 3'd0;
        e.ctrl.rs1_req   = r.req[1];
        e.ctrl.rs2_req   = r.req[0];
        e.pc             = p;
        e.rs1_data       = src_val(r.inst[19:15]);
        e.rs2_data       = src_val(r.inst[24:20]);
        e.alu_num1       = sel_val(r.s1, r.inst, p, e.rs1_data);
        e.alu_num2       = sel_val(r.s2, r.inst, p, e.rs2_data);
        return e;
    endfunction

    task automatic abort(input string msg);
        $display("Timeout: %s", msg);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_row(input int idx, input bit stream, input int id);
        int waited;
        int rnd;
        bit ok;
        waited   = 0;
        ok       = 1'b0;
        in_valid = 1'b1;
        inst     = rows[idx].inst;
        pc       = 32'h1000 + 32'(idx * 4);
        while (!ok && waited < WAIT_LIMIT) begin
            if (stream) begin
                rnd       = $random(seed);
                out_ready = rnd[0];
            end
            #6;
            if (in_ready) begin
                ok = 1'b1;
                if (!rows[idx].hazard) begin
                    exp_issue = expected(rows[idx], pc);
                    exp_id    = id;
                    exp_lat   = stream ? 0 : 2;  // Fixed only with out_ready_i held high
                    exp_push  = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            exp_push = 1'b0;
            waited++;
        end
        in_valid = 1'b0;
        if (!ok) abort("in_ready_o never accepted the instruction");
    endtask

    task automatic wait_checked(input int target);
        int waited;
        waited = 0;
        while (checked < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (checked < target) abort("the expected instruction never left the stage");
    endtask

    initial begin
        int n;
        seed = 32'h36c2;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        inst         = '0;
        pc           = '0;
        out_ready    = 1'b1;
        ex_fwd       = '0;
        mem1_fwd     = '0;
        mem2_fwd     = '0;
        onfly        = '0;
        exp_push     = 1'b0;
        exp_issue    = '0;
        exp_id       = 0;
        exp_lat      = 0;
        stall_expect = 1'b0;
        idle_check   = 1'b0;

        add_row(32'h002081B3, 31, 31, 31, 7, 0, 0, 0, SEL_REG, SEL_REG, WB_ALU, 3,
                CMP_NONE, MEM_NONE, 0, 3);  // ADD
        add_row(32'h407302B3, 31, 31, 31, 7, 0, 0, 8, SEL_REG, SEL_REG, WB_ALU, 5,
                CMP_NONE, MEM_NONE, 0, 3);  // SUB
        add_row(32'h40A4D433, 31, 31, 31, 7, 0, 0, 13, SEL_REG, SEL_REG, WB_ALU, 8,
                CMP_NONE, MEM_NONE, 0, 3);  // SRA
        add_row(32'hFFB08213, 31, 31, 31, 7, 0, 0, 0, SEL_REG, SEL_I, WB_ALU, 4,
                CMP_NONE, MEM_NONE, 0, 2);  // ADDI
        add_row(32'h40765593, 31, 31, 31, 7, 0, 0, 13, SEL_REG, SEL_SHAMT, WB_ALU, 11,
                CMP_NONE, MEM_NONE, 0, 2);  // SRAI
        add_row(32'hABCDE6B7, 31, 31, 31, 7, 0, 0, 0, SEL_Z, SEL_U, WB_ALU, 13,
                CMP_NONE, MEM_NONE, 0, 0);  // LUI
        add_row(32'h12345717, 31, 31, 31, 7, 0, 0, 0, SEL_PC, SEL_U, WB_ALU, 14,
                CMP_NONE, MEM_NONE, 0, 0);  // AUIPC
        add_row(32'h8A5000EF, 31, 31, 31, 7, 0, 0, 0, SEL_PC, SEL_J, WB_PC_NEXT, 1,
                CMP_ALWAYS, MEM_NONE, 0, 0);  // JAL
        add_row(32'h00C18167, 31, 31, 31, 7, 0, 0, 0, SEL_REG, SEL_I, WB_PC_NEXT, 2,
                CMP_ALWAYS, MEM_NONE, 0, 2);  // JALR
        add_row(32'hFE521CE3, 31, 31, 31, 7, 0, 0, 0, SEL_PC, SEL_B, WB_NONE, 0,
                CMP_COMPARE, MEM_NONE, 1, 3);  // BNE
        add_row(32'hFFC3A303, 31, 31, 31, 7, 0, 0, 0, SEL_REG, SEL_I, WB_MEM, 6,
                CMP_NONE, MEM_LD, 2, 2);  // LW
        add_row(32'h0084AA23, 31, 31, 31, 7, 0, 0, 0, SEL_REG, SEL_S, WB_NONE, 0,
                CMP_NONE, MEM_ST, 2, 3);  // SW
        add_row(32'h002081B3, 1, 1, 2, 7, 0, 0, 0, SEL_REG, SEL_REG, WB_ALU, 3,
                CMP_NONE, MEM_NONE, 0, 3);  // EX over MEM1, MEM2 alone
        add_row(32'h001101B3, 9, 2, 2, 7, 0, 0, 0, SEL_REG, SEL_REG, WB_ALU, 3,
                CMP_NONE, MEM_NONE, 0, 3);  // MEM1 over MEM2
        add_row(32'h002001B3, 0, 0, 0, 7, 0, 0, 0, SEL_REG, SEL_REG, WB_ALU, 3,
                CMP_NONE, MEM_NONE, 0, 3);  // x0 reads zero
        add_row(32'h002081B3, 1, 31, 31, 3, 0, 1, 0, SEL_REG, SEL_REG, WB_ALU, 3,
                CMP_NONE, MEM_NONE, 0, 3);  // EX not ready
        add_row(32'hFFC3A303, 31, 31, 31, 7, 31'h40, 1, 0, SEL_REG, SEL_I, WB_MEM, 6,
                CMP_NONE, MEM_LD, 2, 2);  // x7 pending
        add_row(32'hFE521CE3, 31, 31, 5, 6, 0, 1, 0, SEL_PC, SEL_B, WB_NONE, 0,
                CMP_COMPARE, MEM_NONE, 1, 3);  // MEM2 not ready
        add_row(32'hABCDE6B7, 27, 27, 27, 0, '1, 0, 0, SEL_Z, SEL_U, WB_ALU, 13,
                CMP_NONE, MEM_NONE, 0, 0);  // Unrequested source ignored

        repeat (2) @(posedge clk);
        #1;
        rst_n      = 1'b1;
        idle_check = 1'b1;
        @(posedge clk);
        #1;
        idle_check = 1'b0;

        n = 0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_fwd(rows[i], 1'b0);
            send_row(i, 1'b0, n);
            if (rows[i].hazard) begin
                stall_expect = 1'b1;
                repeat (4) begin
                    @(posedge clk);
                    #1;
                end
                stall_expect = 1'b0;
                apply_fwd(rows[i], 1'b1);
                exp_issue = expected(rows[i], pc);
                exp_id    = n;
                exp_lat   = 0;
                exp_push  = 1'b1;
                @(posedge clk);
                #1;
                exp_push = 1'b0;
            end
            n++;
            wait_checked(n);
        end

        apply_fwd(rows[0], 1'b1);
        for (int k = 0; k < 24; k++) begin
            send_row(k % 12, 1'b1, n);
            n++;
        end
        out_ready = 1'b1;
        wait_checked(n);

        $display("Tests checked: %0d of %0d, errors: %0d", checked, n, errors);
        if (errors == 0 && checked == n) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   out_valid_i,
    input  logic   out_ready_i,
    input  logic   in_ready_i,
    input  issue_t issue_i,
    input  logic   exp_push_i,
    input  issue_t exp_issue_i,
    input  int     exp_id_i,
    input  int     exp_lat_i,  // Zero leaves the latency open
    input  logic   stall_expect_i,
    input  logic   idle_check_i,
    output int     checked_o,
    output int     errors_o
);

    issue_t exp_q[$];
    int     id_q[$];
    int     lat_q[$];
    int     start_q[$];
    issue_t held;
    logic   holding;
    int     checked;
    int     errors;
    int     cycle;

    initial begin
        checked = 0;
        errors  = 0;
        holding = 1'b0;
        cycle   = 0;
    end

    assign checked_o = checked;
    assign errors_o  = errors;

    task automatic report(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act, inout bit ok);
        if (exp !== act) begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic compare(input issue_t exp, input int id, input int lat, input int took);
        bit ok;
        ok = 1'b1;
        check_field("issue_o.ctrl", 64'(exp.ctrl), 64'(issue_i.ctrl), ok);
        check_field("issue_o.pc", 64'(exp.pc), 64'(issue_i.pc), ok);
        check_field("issue_o.alu_num1", 64'(exp.alu_num1), 64'(issue_i.alu_num1), ok);
        check_field("issue_o.alu_num2", 64'(exp.alu_num2), 64'(issue_i.alu_num2), ok);
        check_field("issue_o.rs1_data", 64'(exp.rs1_data), 64'(issue_i.rs1_data), ok);
        check_field("issue_o.rs2_data", 64'(exp.rs2_data), 64'(issue_i.rs2_data), ok);
        if (lat != 0) begin
            check_field("out_valid_o latency", 64'(lat), 64'(took), ok);
        end
        $display("test %0d: %s", id, ok ? "ok" : "failed");
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            holding = 1'b0;
        end else begin
            if (exp_push_i) begin
                exp_q.push_back(exp_issue_i);
                id_q.push_back(exp_id_i);
                lat_q.push_back(exp_lat_i);
                start_q.push_back(cycle);
            end
            if (idle_check_i) begin
                if (out_valid_i !== 1'b0 || in_ready_i !== 1'b1) begin
                    $display("Fail at %0t ns: out_valid_o/in_ready_o expected 0/1 got %b/%b",
                             $time, out_valid_i, in_ready_i);
                    errors++;
                end
                $display("test reset: %s", (!out_valid_i && in_ready_i) ? "ok" : "failed");
            end
            if (stall_expect_i && out_valid_i) report("instruction issued while in hazard");
            if (stall_expect_i && in_ready_i) report("input was ready during a stall");
            if (holding && !out_valid_i) report("out_valid_o dropped before the transfer");
            if (holding && out_valid_i && issue_i !== held) begin
                $display("Fail at %0t ns: issue_o (held) expected %h got %h", $time, held, issue_i);
                errors++;
            end
            holding = out_valid_i && !out_ready_i;
            held    = issue_i;
            if (out_valid_i && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    report("output transfer with no instruction expected");
                end else begin
                    compare(exp_q.pop_front(), id_q.pop_front(), lat_q.pop_front(),
                            cycle - start_q.pop_front());
                    checked++;
                end
            end
            cycle++;
        end
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  inst_u               inst_i,
    input  logic [XLEN-1:0]     pc_i,

    output logic [REG_AW-1:0]   reg_raddr1_o,
    output logic [REG_AW-1:0]   reg_raddr2_o,
    input  logic [XLEN-1:0]     reg_rdata1_i,
    input  logic [XLEN-1:0]     reg_rdata2_i,

    input  fwd_src_t            ex_fwd_i,
    input  fwd_src_t            mem1_fwd_i,
    input  fwd_src_t            mem2_fwd_i,
    input  logic [NUM_REGS-1:1] onfly_mask_i,

    output logic                out_valid_o,
    input  logic                out_ready_i,
    output issue_t              issue_o
);

    decode_ctrl_t    dec_ctrl;
    id_entry_t       id_q;
    logic            id_valid_q;
    issue_t          issue_q;
    logic            out_valid_q;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_num1;
    logic [XLEN-1:0] alu_num2;
    logic            rs1_stall;
    logic            rs2_stall;
    logic            out_free;
    logic            id_advance;

    ctrl_decoder u_ctrl_decoder (
        .inst_i (inst_i),
        .ctrl_o (dec_ctrl)
    );

    assign reg_raddr1_o = id_q.inst.r.rs1;
    assign reg_raddr2_o = id_q.inst.r.rs2;

    bypass_unit u_bypass_rs1 (
        .rs_i         (id_q.inst.r.rs1),
        .req_i        (id_q.ctrl.rs1_req),
        .ex_i         (ex_fwd_i),
        .mem1_i       (mem1_fwd_i),
        .mem2_i       (mem2_fwd_i),
        .reg_rdata_i  (reg_rdata1_i),
        .onfly_mask_i (onfly_mask_i),
        .data_o       (rs1_data),
        .stall_o      (rs1_stall)
    );

    bypass_unit u_bypass_rs2 (
        .rs_i         (id_q.inst.r.rs2),
        .req_i        (id_q.ctrl.rs2_req),
        .ex_i         (ex_fwd_i),
        .mem1_i       (mem1_fwd_i),
        .mem2_i       (mem2_fwd_i),
        .reg_rdata_i  (reg_rdata2_i),
        .onfly_mask_i (onfly_mask_i),
        .data_o       (rs2_data),
        .stall_o      (rs2_stall)
    );

    operand_select u_operand_select (
        .inst_i     (id_q.inst),
        .pc_i       (id_q.pc),
        .num1_sel_i (id_q.ctrl.alu_num1_sel),
        .num2_sel_i (id_q.ctrl.alu_num2_sel),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .alu_num1_o (alu_num1),
        .alu_num2_o (alu_num2)
    );

    assign out_free   = ~out_valid_q | out_ready_i;  // Output register empty or draining
    assign id_advance = id_valid_q & ~(rs1_stall | rs2_stall) & out_free;
    assign in_ready_o = ~id_valid_q | id_advance;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_q  <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (in_ready_o) begin
                id_valid_q <= in_valid_i;
            end
            if (out_free) begin
                out_valid_q <= id_advance;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            id_q <= '{inst: inst_i, pc: pc_i, ctrl: dec_ctrl};
        end
        if (id_advance) begin
            issue_q <= '{ctrl: id_q.ctrl, pc: id_q.pc, alu_num1: alu_num1,
                         alu_num2: alu_num2, rs1_data: rs1_data, rs2_data: rs2_data};
        end
    end

    assign out_valid_o = out_valid_q;
    assign issue_o     = issue_q;

endmodule

//--- hw/operand_select.sv
`timescale 1ns/1ps

module operand_select import decode_pkg::*; (
    input  inst_u           inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  alu_sel_e        num1_sel_i,
    input  alu_sel_e        num2_sel_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [XLEN-1:0] alu_num1_o,
    output logic [XLEN-1:0] alu_num2_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] shamt;

    assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_b = {{20{inst_i.b.imm12}}, inst_i.b.imm11, inst_i.b.imm10_5,
                    inst_i.b.imm4_1, 1'b0};
    assign imm_u = {inst_i.u.imm, 12'b0};
    assign imm_j = {{12{inst_i.j.imm20}}, inst_i.j.imm19_12, inst_i.j.imm11,
                    inst_i.j.imm10_1, 1'b0};
    assign shamt = {27'b0, inst_i.r.rs2};  // Shift amount sits in the rs2 field

    // Same source table for both operands, only REG differs
    function automatic logic [XLEN-1:0] pick(alu_sel_e sel, logic [XLEN-1:0] reg_data);
        logic [XLEN-1:0] res;
        case (sel)
            SEL_REG:   res = reg_data;
            SEL_SHAMT: res = shamt;
            SEL_I:     res = imm_i;
            SEL_U:     res = imm_u;
            SEL_PC:    res = pc_i;
            SEL_J:     res = imm_j;
            SEL_S:     res = imm_s;
            SEL_B:     res = imm_b;
            default:   res = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        alu_num1_o = pick(num1_sel_i, rs1_data_i);
        alu_num2_o = pick(num2_sel_i, rs2_data_i);
    end

endmodule

//--- hw/bypass_unit.sv
`timescale 1ns/1ps

module bypass_unit import decode_pkg::*; (
    input  logic [REG_AW-1:0]   rs_i,
    input  logic                req_i,
    input  fwd_src_t            ex_i,
    input  fwd_src_t            mem1_i,
    input  fwd_src_t            mem2_i,
    input  logic [XLEN-1:0]     reg_rdata_i,
    input  logic [NUM_REGS-1:1] onfly_mask_i,
    output logic [XLEN-1:0]     data_o,
    output logic                stall_o
);

    // Candidates: [0] x0, [1] EX, [2] MEM1, [3] MEM2, [4] register file
    logic [4:0]          hit;
    logic [4:0]          sel;
    logic [NUM_REGS-1:0] onfly_full;
    logic                hazard;

    assign hit = {1'b1,
                  rs_i == mem2_i.dst,
                  rs_i == mem1_i.dst,
                  rs_i == ex_i.dst,
                  rs_i == '0};

    assign sel        = hit & ~(hit - 5'd1);  // Lowest set bit wins
    assign onfly_full = {onfly_mask_i, 1'b0};

    always_comb begin
        data_o = '0;
        hazard = 1'b0;
        unique case (1'b1)
            sel[0]: data_o = '0;
            sel[1]: begin
                data_o = ex_i.data;
                hazard = ~ex_i.data_valid;
            end
            sel[2]: begin
                data_o = mem1_i.data;
                hazard = ~mem1_i.data_valid;
            end
            sel[3]: begin
                data_o = mem2_i.data;
                hazard = ~mem2_i.data_valid;
            end
            sel[4]: begin
                data_o = reg_rdata_i;
                hazard = onfly_full[rs_i];  // Write pending past MEM2
            end
            default: begin
            end
        endcase
    end

    assign stall_o = req_i & hazard;

endmodule

//--- hw/ctrl_decoder.sv
`timescale 1ns/1ps

module ctrl_decoder import decode_pkg::*; (
    input  inst_u        inst_i,
    output decode_ctrl_t ctrl_o
);

    always_comb begin
        ctrl_o              = '0;
        ctrl_o.alu_num1_sel = SEL_Z;
        ctrl_o.alu_num2_sel = SEL_Z;
        ctrl_o.wb_sel       = WB_NONE;
        ctrl_o.wb_reg       = inst_i.r.rd;
        ctrl_o.pc_sel       = PC_SEQ;
        ctrl_o.cmp_op       = CMP_NONE;
        ctrl_o.mem_op       = MEM_NONE;

        case (inst_i.r.opcode)
            OP_ALU_R: begin
                // Only the base integer encodings carry an op
                if (inst_i.r.funct7 == 7'b0000000 || inst_i.r.funct7 == 7'b0100000) begin
                    ctrl_o.alu_op = {inst_i.r.funct7[5], inst_i.r.funct3};
                end
                ctrl_o.alu_num1_sel = SEL_REG;
                ctrl_o.alu_num2_sel = SEL_REG;
                ctrl_o.wb_sel       = WB_ALU;
                ctrl_o.rs1_req      = 1'b1;
                ctrl_o.rs2_req      = 1'b1;
            end
            OP_ALU_I: begin
                ctrl_o.alu_num1_sel = SEL_REG;
                ctrl_o.wb_sel       = WB_ALU;
                ctrl_o.rs1_req      = 1'b1;
                if (inst_i.r.funct3 == 3'b101) begin  // SRLI/SRAI
                    ctrl_o.alu_op       = {inst_i.r.funct7[5], inst_i.r.funct3};
                    ctrl_o.alu_num2_sel = SEL_SHAMT;
                end else begin
                    ctrl_o.alu_op       = {1'b0, inst_i.r.funct3};
                    ctrl_o.alu_num2_sel = SEL_I;
                end
            end
            OP_LUI: begin
                ctrl_o.alu_num2_sel = SEL_U;  // Zero plus upper immediate
                ctrl_o.wb_sel       = WB_ALU;
            end
            OP_AUIPC: begin
                ctrl_o.alu_num1_sel = SEL_PC;
                ctrl_o.alu_num2_sel = SEL_U;
                ctrl_o.wb_sel       = WB_ALU;
            end
            OP_JAL: begin
                ctrl_o.alu_num1_sel = SEL_PC;
                ctrl_o.alu_num2_sel = SEL_J;
                ctrl_o.wb_sel       = WB_PC_NEXT;
                ctrl_o.pc_sel       = PC_BRANCH;
                ctrl_o.cmp_op       = CMP_ALWAYS;
            end
            OP_JALR: begin
                ctrl_o.alu_num1_sel = SEL_REG;
                ctrl_o.alu_num2_sel = SEL_I;
                ctrl_o.wb_sel       = WB_PC_NEXT;
                ctrl_o.pc_sel       = PC_BRANCH;
                ctrl_o.cmp_op       = CMP_ALWAYS;
                ctrl_o.rs1_req      = 1'b1;
            end
            OP_BRANCH: begin
                ctrl_o.alu_num1_sel = SEL_PC;  // Target address
                ctrl_o.alu_num2_sel = SEL_B;
                ctrl_o.wb_reg       = '0;
                ctrl_o.pc_sel       = PC_BRANCH;
                ctrl_o.cmp_op       = CMP_COMPARE;
                ctrl_o.cmp_funct    = inst_i.r.funct3;
                ctrl_o.rs1_req      = 1'b1;
                ctrl_o.rs2_req      = 1'b1;
            end
            OP_LOAD: begin
                ctrl_o.alu_num1_sel = SEL_REG;
                ctrl_o.alu_num2_sel = SEL_I;
                ctrl_o.wb_sel       = WB_MEM;
                ctrl_o.mem_op       = MEM_LD;
                ctrl_o.mem_funct    = inst_i.r.funct3;
                ctrl_o.rs1_req      = 1'b1;
            end
            OP_STORE: begin
                ctrl_o.alu_num1_sel = SEL_REG;
                ctrl_o.alu_num2_sel = SEL_S;
                ctrl_o.wb_reg       = '0;
                ctrl_o.mem_op       = MEM_ST;
                ctrl_o.mem_funct    = inst_i.r.funct3;
                ctrl_o.rs1_req      = 1'b1;
                ctrl_o.rs2_req      = 1'b1;  // Store data
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/decode_pkg.sv
package decode_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 1 << REG_AW;

    // Major opcode, inst[6:2]
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_ALU_I  = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_ALU_R  = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        SEL_REG, SEL_SHAMT, SEL_I, SEL_U, SEL_PC, SEL_J, SEL_S, SEL_B, SEL_Z
    } alu_sel_e;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_PC_NEXT, WB_MEM} wb_sel_e;
    typedef enum logic [1:0] {CMP_NONE, CMP_ALWAYS, CMP_COMPARE} cmp_op_e;
    typedef enum logic [1:0] {MEM_NONE, MEM_LD, MEM_ST} mem_op_e;
    typedef enum logic {PC_SEQ, PC_BRANCH} pc_sel_e;

    // Instruction formats, all 32 bits wide
    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
        logic [1:0]        len;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
        logic [1:0]        len;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        opcode_e           opcode;
        logic [1:0]        len;
    } s_fmt_t;

    typedef struct packed {
        logic              imm12;
        logic [5:0]        imm10_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm4_1;
        logic              imm11;
        opcode_e           opcode;
        logic [1:0]        len;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]       imm;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
        logic [1:0]        len;
    } u_fmt_t;

    typedef struct packed {
        logic              imm20;
        logic [9:0]        imm10_1;
        logic              imm11;
        logic [7:0]        imm19_12;
        logic [REG_AW-1:0] rd;
        opcode_e           opcode;
        logic [1:0]        len;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        logic [3:0]        alu_op;
        alu_sel_e          alu_num1_sel;
        alu_sel_e          alu_num2_sel;
        wb_sel_e           wb_sel;
        logic [REG_AW-1:0] wb_reg;
        pc_sel_e           pc_sel;
        cmp_op_e           cmp_op;
        logic [2:0]        cmp_funct;
        mem_op_e           mem_op;
        logic [2:0]        mem_funct;
        logic              rs1_req;
        logic              rs2_req;
    } decode_ctrl_t;

    typedef struct packed {
        inst_u           inst;
        logic [XLEN-1:0] pc;
        decode_ctrl_t    ctrl;
    } id_entry_t;

    // Result bus from one producing stage
    typedef struct packed {
        logic [REG_AW-1:0] dst;
        logic [XLEN-1:0]   data;
        logic              data_valid;
    } fwd_src_t;

    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu_num1;
        logic [XLEN-1:0] alu_num2;
        logic [XLEN-1:0] rs1_data;  // Compare operand 1
        logic [XLEN-1:0] rs2_data;  // Compare operand 2, store data
    } issue_t;

endpackage
